// ==== common/rv_pkg.sv ====
// rv isa package, opcodes, branch function codes and instruction length
`default_nettype none

package rv_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // major opcodes
  typedef enum logic [6:0] {
    OP_BRANCH = 7'b1100011,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_SYSTEM = 7'b1110011,
    // other group, never redirects
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_OPIMM  = 7'b0010011,
    OP_OP     = 7'b0110011,
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111
  } opcode_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // branch function code
  typedef enum logic [2:0] {
    BR_JAL  = 3'b000, // unconditional
    BR_JALR = 3'b001, // unconditional
    BR_BEQ  = 3'b010,
    BR_BNE  = 3'b011,
    BR_BLT  = 3'b100, // signed
    BR_BGE  = 3'b101, // signed
    BR_BLTU = 3'b110, // unsigned
    BR_BGEU = 3'b111  // unsigned
  } brfunc_e;

  localparam int unsigned ILEN_BYTES  = 4;
  localparam logic [31:0] INSTR_ECALL = 32'h0000_0073;
  localparam logic [31:0] INSTR_MRET  = 32'h3020_0073;

  // reserved funct3 (010, 011) comes back as BR_JAL, never a legal branch
  function automatic brfunc_e funct3_to_brfunc(input logic [2:0] funct3);
    case (funct3)
      3'b000:  return BR_BEQ;
      3'b001:  return BR_BNE;
      3'b100:  return BR_BLT;
      3'b101:  return BR_BGE;
      3'b110:  return BR_BLTU;
      3'b111:  return BR_BGEU;
      default: return BR_JAL;
    endcase
  endfunction

endpackage

`default_nettype wire

// ==== common/bru_pkg.sv ====
// branch unit pipeline payloads passed between decode, execute and redirect
`default_nettype none

package bru_pkg;

  // widest configuration, stages use only the low XLEN / PC_WD bits
  localparam int unsigned MAX_XLEN = 64;
  localparam int unsigned MAX_PC   = 64;
  localparam int unsigned REG_AW   = 5;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // decode -> execute
  typedef struct packed {
    logic                  valid;
    logic                  bren;    // branch or jump
    rv_pkg::brfunc_e       brfunc;
    logic                  ep_sel;  // ecall / mret
    logic                  link;    // jal / jalr write rd
    logic [REG_AW-1:0]     rd;
    logic [MAX_PC-1:0]     pc;
    logic [MAX_XLEN-1:0]   rs1data;
    logic [MAX_XLEN-1:0]   rs2data;
    logic [MAX_XLEN-1:0]   imm;     // sign extended
    logic [MAX_PC-1:0]     epnpc;
  } dec_pkt_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // execute -> redirect
  typedef struct packed {
    logic                  valid;
    logic                  taken;
    logic [MAX_PC-1:0]     target;
    logic                  link;
    logic [REG_AW-1:0]     rd;
    logic [MAX_XLEN-1:0]   link_data; // pc + 4
  } exe_pkt_t;

endpackage

`default_nettype wire

// ==== verilog/br_decode.sv ====
// branch decode stage, extracts branch controls and immediate and registers them
`timescale 1ns/1ps
`default_nettype none

module br_decode #(
  parameter int unsigned XLEN  = 64,
  parameter int unsigned PC_WD = 64
) (
  input  wire logic             i_clk,
  input  wire logic             i_arst_n,
  input  wire logic             i_valid,
  input  wire logic [31:0]      i_instr,
  input  wire logic [PC_WD-1:0] i_pc,
  input  wire logic [XLEN-1:0]  i_rs1data,
  input  wire logic [XLEN-1:0]  i_rs2data,
  input  wire logic [PC_WD-1:0] i_epnpc,
  input  wire logic             i_flush,
  output bru_pkg::dec_pkt_t     o_pkt
);

  import rv_pkg::*;
  import bru_pkg::*;

  opcode_e           opcode;
  logic [2:0]        funct3;
  brfunc_e           cond_func;
  logic [MAX_XLEN-1:0] imm_b;
  logic [MAX_XLEN-1:0] imm_j;
  logic [MAX_XLEN-1:0] imm_i;
  dec_pkt_t          pkt_d;
  dec_pkt_t          pkt_q;
  logic              valid_q;

  assign opcode    = opcode_e'(i_instr[6:0]);
  assign funct3    = i_instr[14:12];
  assign cond_func = funct3_to_brfunc(funct3);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // immediates
  assign imm_b = {{(MAX_XLEN-12){i_instr[31]}}, i_instr[7], i_instr[30:25],
                  i_instr[11:8], 1'b0};
  assign imm_j = {{(MAX_XLEN-20){i_instr[31]}}, i_instr[19:12], i_instr[20],
                  i_instr[30:21], 1'b0};
  assign imm_i = {{(MAX_XLEN-11){i_instr[31]}}, i_instr[30:20]};

  always_comb begin
    pkt_d         = '0;
    pkt_d.valid   = i_valid;
    pkt_d.brfunc  = BR_BEQ;
    pkt_d.rd      = i_instr[11:7];
    pkt_d.pc      = MAX_PC'(i_pc);
    pkt_d.rs1data = MAX_XLEN'(i_rs1data);
    pkt_d.rs2data = MAX_XLEN'(i_rs2data);
    pkt_d.epnpc   = MAX_PC'(i_epnpc);
    case (opcode)
      OP_BRANCH: begin
        pkt_d.bren   = (cond_func != BR_JAL); // reserved funct3 stays a non-branch
        pkt_d.brfunc = cond_func;
        pkt_d.imm    = imm_b;
      end
      OP_JAL: begin
        pkt_d.bren   = 1'b1;
        pkt_d.brfunc = BR_JAL;
        pkt_d.link   = 1'b1;
        pkt_d.imm    = imm_j;
      end
      OP_JALR: begin
        pkt_d.bren   = 1'b1;
        pkt_d.brfunc = BR_JALR;
        pkt_d.link   = 1'b1;
        pkt_d.imm    = imm_i;
      end
      OP_SYSTEM: begin
        pkt_d.ep_sel = (i_instr == INSTR_ECALL) || (i_instr == INSTR_MRET);
      end
      default: begin
        pkt_d.bren   = 1'b0; // other opcodes pass through
      end
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stage register
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= i_valid & ~i_flush; // younger slot killed by a taken branch
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      pkt_q <= pkt_d;
    end
  end

  always_comb begin
    o_pkt       = pkt_q;
    o_pkt.valid = valid_q;
  end

  // a captured branch is marked bren exactly when its funct3 is a legal compare
  a_brfunc_legal : assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (i_valid && !i_flush && opcode == OP_BRANCH) |=>
      (o_pkt.bren == ($past(funct3) inside {3'b000, 3'b001, 3'b100, 3'b101,
                                            3'b110, 3'b111})));

endmodule

`default_nettype wire

// ==== bru/bru_exec.sv ====
// branch execute stage, resolves compare, taken and target and registers the result
`timescale 1ns/1ps
`default_nettype none

module bru_exec #(
  parameter int unsigned XLEN  = 64,
  parameter int unsigned PC_WD = 64
) (
  input  wire logic          i_clk,
  input  wire logic          i_arst_n,
  input  bru_pkg::dec_pkt_t  i_pkt,
  input  wire logic          i_flush,
  output bru_pkg::exe_pkt_t  o_pkt
);

  import rv_pkg::*;
  import bru_pkg::*;

  logic [XLEN-1:0]  rs1;
  logic [XLEN-1:0]  rs2;
  logic [XLEN-1:0]  sub_res;
  logic             cout;
  logic             overflow;
  logic             zero;
  logic             signed_less;
  logic             unsigned_less;
  logic             less;
  logic             cond_hit;
  logic             taken;
  logic             is_jalr;
  logic [PC_WD-1:0] pc;
  logic [PC_WD-1:0] imm;
  logic [PC_WD-1:0] jalr_sum;
  logic [PC_WD-1:0] target;
  exe_pkt_t         pkt_d;
  exe_pkt_t         pkt_q;
  logic             valid_q;

  assign rs1 = i_pkt.rs1data[XLEN-1:0];
  assign rs2 = i_pkt.rs2data[XLEN-1:0];
  assign pc  = i_pkt.pc[PC_WD-1:0];
  assign imm = i_pkt.imm[PC_WD-1:0];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // compare through one subtract
  assign {cout, sub_res} = {1'b0, rs1} + {1'b0, ~rs2} + (XLEN+1)'(1);

  assign overflow      = (rs1[XLEN-1] != rs2[XLEN-1]) && (sub_res[XLEN-1] != rs1[XLEN-1]);
  assign signed_less   = sub_res[XLEN-1] ^ overflow;
  assign unsigned_less = ~cout;                // no carry out means a borrow
  assign zero          = ~(|sub_res);
  assign less          = i_pkt.brfunc[1] ? unsigned_less : signed_less;

  always_comb begin
    case (i_pkt.brfunc)
      BR_JAL, BR_JALR: cond_hit = 1'b1;
      BR_BEQ:          cond_hit = zero;
      BR_BNE:          cond_hit = ~zero;
      BR_BLT, BR_BLTU: cond_hit = less;
      BR_BGE, BR_BGEU: cond_hit = ~less;
      default:         cond_hit = 1'b0;
    endcase
  end

  assign taken   = (i_pkt.bren & cond_hit) | i_pkt.ep_sel;
  assign is_jalr = i_pkt.bren && (i_pkt.brfunc == BR_JALR);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // target
  assign jalr_sum = i_pkt.rs1data[PC_WD-1:0] + imm;

  always_comb begin
    if (i_pkt.ep_sel) begin
      target = i_pkt.epnpc[PC_WD-1:0];
    end else if (is_jalr) begin
      target = {jalr_sum[PC_WD-1:1], 1'b0};
    end else if (taken) begin
      target = pc + imm;
    end else begin
      target = pc + PC_WD'(ILEN_BYTES);
    end
  end

  always_comb begin
    pkt_d           = '0;
    pkt_d.valid     = i_pkt.valid;
    pkt_d.taken     = taken;
    pkt_d.target    = MAX_PC'(target);
    pkt_d.link      = i_pkt.link;
    pkt_d.rd        = i_pkt.rd;
    pkt_d.link_data = MAX_XLEN'(pc + PC_WD'(ILEN_BYTES));
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stage register
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= i_pkt.valid & ~i_flush;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_pkt.valid) begin
      pkt_q <= pkt_d;
    end
  end

  always_comb begin
    o_pkt       = pkt_q;
    o_pkt.valid = valid_q;
  end

  // trap/return and unconditional jumps always resolve taken a cycle later
  a_uncond_taken : assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (i_pkt.valid && !i_flush && (i_pkt.ep_sel || (i_pkt.bren && i_pkt.link))) |=>
      (o_pkt.valid && o_pkt.taken));

endmodule

`default_nettype wire

// ==== verilog/redirect_ctrl.sv ====
// redirect stage, issues redirect pulse, link write, misalign flag and flush
`timescale 1ns/1ps
`default_nettype none

module redirect_ctrl #(
  parameter int unsigned XLEN  = 64,
  parameter int unsigned PC_WD = 64
) (
  input  wire logic             i_clk,
  input  wire logic             i_arst_n,
  input  bru_pkg::exe_pkt_t     i_pkt,
  output logic                  o_flush,
  output logic                  o_res_valid,
  output logic                  o_redirect,
  output logic [PC_WD-1:0]      o_redirect_pc,
  output logic                  o_misalign,
  output logic [PC_WD-1:0]      o_bad_target,
  output logic                  o_rd_we,
  output logic [4:0]            o_rd_addr,
  output logic [XLEN-1:0]       o_rd_data
);

  logic [PC_WD-1:0] target;
  logic             misal;
  logic             take;
  logic             res_valid_q;
  logic             redirect_q;
  logic             misalign_q;
  logic             rd_we_q;
  logic [PC_WD-1:0] target_q;
  logic [4:0]       rd_addr_q;
  logic [XLEN-1:0]  rd_data_q;

  assign target = i_pkt.target[PC_WD-1:0];
  assign misal  = |target[1:0];
  assign take   = i_pkt.valid & i_pkt.taken;

  // kills the two younger instructions in decode and execute
  assign o_flush = take;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // result strobes
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      res_valid_q <= 1'b0;
      redirect_q  <= 1'b0;
      misalign_q  <= 1'b0;
      rd_we_q     <= 1'b0;
    end else begin
      res_valid_q <= i_pkt.valid;
      redirect_q  <= take & ~misal;
      misalign_q  <= take & misal;  // exception instead of redirect
      rd_we_q     <= i_pkt.valid & i_pkt.link & (|i_pkt.rd);
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_pkt.valid) begin
      target_q  <= target;
      rd_addr_q <= i_pkt.rd;
      rd_data_q <= i_pkt.link_data[XLEN-1:0]; // pc + 4
    end
  end

  assign o_res_valid   = res_valid_q;
  assign o_redirect    = redirect_q;
  assign o_misalign    = misalign_q;
  assign o_redirect_pc = target_q;
  assign o_bad_target  = target_q;
  assign o_rd_we       = rd_we_q;
  assign o_rd_addr     = rd_addr_q;
  assign o_rd_data     = rd_data_q;

  a_redir_xor_misal : assert property (@(posedge i_clk) disable iff (!i_arst_n)
    !(o_redirect && o_misalign));

  // the two younger slots reach this stage already dropped
  a_flush_kills : assert property (@(posedge i_clk) disable iff (!i_arst_n)
    ($past(o_flush) || $past(o_flush, 2)) |-> !i_pkt.valid);

endmodule

`default_nettype wire

// ==== verilog/br_unit_top.sv ====
// branch unit top, chains decode, execute and redirect stages
`timescale 1ns/1ps
`default_nettype none

module br_unit_top #(
  parameter int unsigned XLEN  = 64,
  parameter int unsigned PC_WD = 64
) (
  input  wire logic             i_clk,
  input  wire logic             i_arst_n,
  input  wire logic             i_valid,
  input  wire logic [31:0]      i_instr,
  input  wire logic [PC_WD-1:0] i_pc,
  input  wire logic [XLEN-1:0]  i_rs1data,
  input  wire logic [XLEN-1:0]  i_rs2data,
  input  wire logic [PC_WD-1:0] i_epnpc,
  output logic                  o_res_valid,
  output logic                  o_redirect,
  output logic [PC_WD-1:0]      o_redirect_pc,
  output logic                  o_misalign,
  output logic [PC_WD-1:0]      o_bad_target,
  output logic                  o_rd_we,
  output logic [4:0]            o_rd_addr,
  output logic [XLEN-1:0]       o_rd_data
);

  import bru_pkg::*;

  dec_pkt_t dec_pkt;
  exe_pkt_t exe_pkt;
  logic     flush;

  br_decode #(.XLEN(XLEN), .PC_WD(PC_WD)) u_decode (
    .i_clk     (i_clk),
    .i_arst_n  (i_arst_n),
    .i_valid   (i_valid),
    .i_instr   (i_instr),
    .i_pc      (i_pc),
    .i_rs1data (i_rs1data),
    .i_rs2data (i_rs2data),
    .i_epnpc   (i_epnpc),
    .i_flush   (flush),
    .o_pkt     (dec_pkt)
  );

  bru_exec #(.XLEN(XLEN), .PC_WD(PC_WD)) u_exec (
    .i_clk     (i_clk),
    .i_arst_n  (i_arst_n),
    .i_pkt     (dec_pkt),
    .i_flush   (flush),
    .o_pkt     (exe_pkt)
  );

  redirect_ctrl #(.XLEN(XLEN), .PC_WD(PC_WD)) u_redirect (
    .i_clk         (i_clk),
    .i_arst_n      (i_arst_n),
    .i_pkt         (exe_pkt),
    .o_flush       (flush),
    .o_res_valid   (o_res_valid),
    .o_redirect    (o_redirect),
    .o_redirect_pc (o_redirect_pc),
    .o_misalign    (o_misalign),
    .o_bad_target  (o_bad_target),
    .o_rd_we       (o_rd_we),
    .o_rd_addr     (o_rd_addr),
    .o_rd_data     (o_rd_data)
  );

endmodule

`default_nettype wire

// ==== sim/br_ref_model.svh ====
// branch unit reference model, resolves each strobed instruction and queues its expected result
`ifndef BR_REF_MODEL_SVH
`define BR_REF_MODEL_SVH

typedef struct packed {
  int          slot;      // capture edge of the strobe
  logic [2:0]  kind;
  logic        redirect;
  logic        misalign;
  logic [63:0] target;
  logic        rd_we;
  logic [4:0]  rd;
  logic [63:0] rd_data;
} exp_res_t;

exp_res_t exp_q[$];
int       kill_until = -1; // last slot shadowed by a taken instruction
int       n_killed   = 0;

function automatic string kind_name(input logic [2:0] kind);
  case (kind)
    3'd1:    return "branch";
    3'd2:    return "jal";
    3'd3:    return "jalr";
    3'd4:    return "ecall_mret";
    3'd5:    return "system";
    default: return "other";
  endcase
endfunction

function automatic logic [63:0] sext(input logic [63:0] v, input int bits);
  logic [63:0] mask;
  mask = ~64'd0 << bits;
  return v[bits-1] ? (v | mask) : (v & ~mask);
endfunction

function automatic exp_res_t resolve(input logic [31:0] instr, input logic [63:0] pc,
                                     input logic [63:0] rs1, input logic [63:0] rs2,
                                     input logic [63:0] epnpc, input int slot);
  exp_res_t r;
  logic     taken;
  logic     link;
  r        = '0;
  r.slot   = slot;
  r.target = pc + 64'd4;
  taken    = 1'b0;
  link     = 1'b0;
  case (instr[6:0])
    7'b1100011: begin
      r.kind = 3'd1;
      case (instr[14:12])
        3'b000:  taken = (rs1 == rs2);
        3'b001:  taken = (rs1 != rs2);
        3'b100:  taken = ($signed(rs1) < $signed(rs2));
        3'b101:  taken = ($signed(rs1) >= $signed(rs2));
        3'b110:  taken = (rs1 < rs2);
        3'b111:  taken = (rs1 >= rs2);
        default: taken = 1'b0; // reserved funct3 is no branch
      endcase
      if (taken) begin
        r.target = pc + sext({51'd0, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0}, 13);
      end
    end
    7'b1101111: begin
      r.kind   = 3'd2;
      taken    = 1'b1;
      link     = 1'b1;
      r.target = pc + sext({43'd0, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0}, 21);
    end
    7'b1100111: begin
      r.kind   = 3'd3;
      taken    = 1'b1;
      link     = 1'b1;
      r.target = (rs1 + sext({52'd0, instr[31:20]}, 12)) & ~64'd1;
    end
    7'b1110011: begin
      if (instr == 32'h0000_0073 || instr == 32'h3020_0073) begin
        r.kind   = 3'd4;
        taken    = 1'b1;
        r.target = epnpc;
      end else begin
        r.kind = 3'd5;
      end
    end
    default: r.kind = 3'd0;
  endcase
  r.redirect = taken && (r.target[1:0] == 2'b00);
  r.misalign = taken && (r.target[1:0] != 2'b00);
  r.rd       = instr[11:7];
  r.rd_we    = link && (instr[11:7] != 5'd0);
  r.rd_data  = pc + 64'd4;
  return r;
endfunction

task automatic model_accept(input int slot, input logic [31:0] instr, input logic [63:0] pc,
                            input logic [63:0] rs1, input logic [63:0] rs2,
                            input logic [63:0] epnpc);
  exp_res_t r;
  if (slot <= kill_until) begin
    n_killed++; // shadow of an older taken instruction
  end else begin
    r = resolve(instr, pc, rs1, rs2, epnpc, slot);
    exp_q.push_back(r);
    if (r.redirect || r.misalign) kill_until = slot + 2;
  end
endtask

`endif

// ==== sim/tb_br_unit.sv ====
// testbench for the branch unit, seeded random instructions checked against a reference model
`timescale 1ns/1ps
`default_nettype none

module tb_br_unit;

  localparam int XLEN       = 64;
  localparam int PC_WD      = 64;
  localparam int NUM_CYCLES = 2000;
  localparam int DRAIN_MAX  = 20;

  logic             clk = 1'b0;
  logic             arst_n;
  logic             valid;
  logic [31:0]      instr;
  logic [PC_WD-1:0] pc;
  logic [XLEN-1:0]  rs1data;
  logic [XLEN-1:0]  rs2data;
  logic [PC_WD-1:0] epnpc;
  logic             res_valid;
  logic             redirect;
  logic [PC_WD-1:0] redirect_pc;
  logic             misalign;
  logic [PC_WD-1:0] bad_target;
  logic             rd_we;
  logic [4:0]       rd_addr;
  logic [XLEN-1:0]  rd_data;
  int               cyc       = 0;
  int               errors    = 0;
  int               n_results = 0;

  `include "br_ref_model.svh"

  br_unit_top #(.XLEN(XLEN), .PC_WD(PC_WD)) DUT (
    .i_clk         (clk),
    .i_arst_n      (arst_n),
    .i_valid       (valid),
    .i_instr       (instr),
    .i_pc          (pc),
    .i_rs1data     (rs1data),
    .i_rs2data     (rs2data),
    .i_epnpc       (epnpc),
    .o_res_valid   (res_valid),
    .o_redirect    (redirect),
    .o_redirect_pc (redirect_pc),
    .o_misalign    (misalign),
    .o_bad_target  (bad_target),
    .o_rd_we       (rd_we),
    .o_rd_addr     (rd_addr),
    .o_rd_data     (rd_data)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1; // edge count, used as strobe slot
  end

  task automatic mismatch(input string name, input string field,
                          input logic [63:0] exp, input logic [63:0] act);
    errors++;
    $display("ERR %s %s at cycle %0d expected %h actual %h", name, field, cyc, exp, act);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // scoreboard
  task automatic check_outputs();
    exp_res_t e;
    string    name;
    if (res_valid) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("result strobe at cycle %0d with no instruction outstanding", cyc);
      end else begin
        e    = exp_q.pop_front();
        name = kind_name(e.kind);
        n_results++;
        if (cyc != e.slot + 2) mismatch(name, "result cycle", 64'(e.slot + 2), 64'(cyc));
        if (redirect !== e.redirect) mismatch(name, "redirect", 64'(e.redirect), 64'(redirect));
        if (misalign !== e.misalign) mismatch(name, "misalign", 64'(e.misalign), 64'(misalign));
        if (rd_we !== e.rd_we) mismatch(name, "rd_we", 64'(e.rd_we), 64'(rd_we));
        if (e.redirect && redirect_pc !== e.target) mismatch(name, "redirect_pc", e.target, redirect_pc);
        if (e.misalign && bad_target !== e.target) mismatch(name, "bad_target", e.target, bad_target);
        if (e.rd_we && rd_addr !== e.rd) mismatch(name, "rd_addr", 64'(e.rd), 64'(rd_addr));
        if (e.rd_we && rd_data !== e.rd_data) mismatch(name, "rd_data", e.rd_data, rd_data);
      end
    end else begin
      if (redirect || misalign || rd_we) begin
        errors++;
        $display("output strobe high at cycle %0d without a result", cyc);
      end
      if (exp_q.size() > 0 && cyc >= exp_q[0].slot + 2) begin
        e = exp_q.pop_front();
        errors++;
        $display("no result for %s strobed at slot %0d", kind_name(e.kind), e.slot);
      end
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus
  function automatic logic [63:0] rand64();
    return {$urandom, $urandom};
  endfunction

  function automatic logic [63:0] edge_value();
    case ($urandom_range(0, 5))
      0:       return 64'd0;
      1:       return 64'd1;
      2:       return ~64'd0;
      3:       return 64'h8000_0000_0000_0000; // most negative
      4:       return 64'h7fff_ffff_ffff_ffff;
      default: return 64'h0000_0000_8000_0000;
    endcase
  endfunction

  function automatic logic [31:0] make_instr();
    logic [31:0] w;
    int          pick;
    int          f3;
    w    = $urandom;
    pick = $urandom_range(0, 99);
    f3   = $urandom_range(0, 5);
    if (pick < 35) begin
      w[6:0]   = 7'b1100011;
      w[14:12] = 3'(f3 < 2 ? f3 : f3 + 2); // legal funct3 only
    end else if (pick < 50) begin
      w[6:0] = 7'b1101111;
      if ($urandom_range(0, 3) == 0) w[11:7] = 5'd0;
    end else if (pick < 65) begin
      w[6:0]   = 7'b1100111;
      w[14:12] = 3'b000;
      if ($urandom_range(0, 3) == 0) w[11:7] = 5'd0;
    end else if (pick < 75) begin
      w = ($urandom_range(0, 1) == 0) ? 32'h0000_0073 : 32'h3020_0073;
    end else if (pick < 80) begin
      w[6:0]   = 7'b1110011;
      w[14:12] = 3'($urandom_range(1, 7)); // csr access, no trap
    end else begin
      case (f3)
        0:       w[6:0] = 7'b0000011;
        1:       w[6:0] = 7'b0100011;
        2:       w[6:0] = 7'b0010011;
        3:       w[6:0] = 7'b0110011;
        4:       w[6:0] = 7'b0110111;
        default: w[6:0] = 7'b0010111;
      endcase
    end
    return w;
  endfunction

  task automatic drive_next();
    if ($urandom_range(0, 9) == 0) begin
      valid = 1'b0; // idle slot
    end else begin
      valid = 1'b1;
      instr = make_instr();
      pc    = rand64() & ~64'd3;
      epnpc = rand64() & ~64'd3;
      if ($urandom_range(0, 3) == 0) epnpc[1:0] = 2'($urandom_range(1, 3));
      case ($urandom_range(0, 3))
        0: begin
          rs1data = rand64();
          rs2data = rs1data;
        end
        1: begin
          rs1data = edge_value();
          rs2data = edge_value();
        end
        2: begin
          rs1data = edge_value();
          rs2data = ($urandom_range(0, 1) == 0) ? rs1data + 64'd1 : rs1data - 64'd1;
        end
        default: begin
          rs1data = rand64();
          rs2data = rand64();
        end
      endcase
      model_accept(cyc + 1, instr, pc, rs1data, rs2data, epnpc);
    end
  endtask

  initial begin
    int waited;
    void'($urandom(94469));
    arst_n  = 1'b0;
    valid   = 1'b0;
    instr   = '0;
    pc      = '0;
    rs1data = '0;
    rs2data = '0;
    epnpc   = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    repeat (3) begin
      @(negedge clk);
      check_outputs(); // quiet until the first strobe
    end
    repeat (NUM_CYCLES) begin
      @(negedge clk);
      check_outputs();
      drive_next();
    end
    @(negedge clk);
    check_outputs();
    valid  = 1'b0;
    waited = 0;
    while (exp_q.size() > 0 && waited < DRAIN_MAX) begin
      @(negedge clk);
      check_outputs();
      waited++;
    end
    if (exp_q.size() > 0) begin
      errors++;
      $display("timed out with %0d results still outstanding", exp_q.size());
    end
    repeat (3) begin
      @(negedge clk);
      check_outputs();
    end
    $display("results %0d, killed %0d, errors %0d", n_results, n_killed, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+sim
common/rv_pkg.sv
common/bru_pkg.sv
verilog/br_decode.sv
bru/bru_exec.sv
verilog/redirect_ctrl.sv
verilog/br_unit_top.sv
sim/tb_br_unit.sv

// ==== run.sh ====
#!/bin/sh
# build and run the branch unit testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_br_unit -f files.f -o sim_br_unit

./obj_dir/sim_br_unit 2>&1 | tee sim.log

if grep -qx "Test OK" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi
